// File: logic/mailbox_defs.svh
`ifndef MAILBOX_DEFS_SVH
`define MAILBOX_DEFS_SVH

`define MB_NUM_READERS 3
`define MB_ID_W        8
`define MB_BUDGET_W    12
`define MB_MSG_W       32
`define MB_YIELD_ID    8'd255    // Owner field of a yield request
`define MB_UNLIMITED   12'hfff   // Budget field that never counts down
`define MB_STACK_DEPTH 4
`define MB_STACK_PTR_W 3
`define MB_STACK_IDX_W 2
`define MB_QUEUE_DEPTH 4
`define MB_QUEUE_PTR_W 2
`define MB_QUEUE_CNT_W 3
`define MB_TICK_PERIOD 16        // Cycles per timeout step
`define MB_TICK_W      4

`endif

// File: logic/mailbox_pkg.sv
`include "mailbox_defs.svh"

package mailbox_pkg;

	typedef logic [`MB_ID_W-1:0]        owner_id_t;     // 255 requests a yield
	typedef logic [`MB_BUDGET_W-1:0]    budget_t;       // Limit or timeout count
	typedef logic [`MB_MSG_W-1:0]       msg_word_t;
	typedef logic [`MB_NUM_READERS-1:0] reader_mask_t;  // One bit per reader

	// Owner and budget, 32 bits, same layout as the saved stack entries
	typedef struct packed {
		owner_id_t owner;
		budget_t   limit;
		budget_t   timeout;
	} owner_state_t;

	typedef enum logic {
		st_run,
		st_flush   // One cycle after every change of owner
	} arb_state_e;

endpackage

// File: logic/owner_fsm.sv
`timescale 1ns/1ns
`include "mailbox_defs.svh"

module owner_fsm (
	input  logic                                           clk,
	input  logic                                           resetn,
	input  mailbox_pkg::reader_mask_t                      req_valid,
	output mailbox_pkg::reader_mask_t                      req_ready,
	input  mailbox_pkg::owner_state_t [`MB_NUM_READERS-1:0] req_state,
	input  logic                                           tick,
	input  logic                                           read_fire,
	input  mailbox_pkg::owner_state_t                      top_state,
	input  logic                                           stack_empty,
	input  logic                                           stack_full,
	output logic                                           push,
	output logic                                           pop,
	output mailbox_pkg::owner_state_t                      push_state,
	output logic                                           flush,
	output logic                                           read_enable,
	output mailbox_pkg::owner_id_t                         owner,
	output mailbox_pkg::owner_state_t                      owner_state
);
	import mailbox_pkg::*;

	arb_state_e   state;
	owner_state_t cur;        // Current owner and its remaining budget
	owner_state_t req_sel;    // Request from the current owner
	owner_state_t pop_state;
	owner_state_t dec_state;
	logic         in_run;
	logic         accept;
	logic         is_yield;
	logic         is_valid;
	logic         exhausted;

	// Saturating step, unlimited and zero fields hold
	function automatic budget_t dec_budget(input budget_t value, input logic en);
		if (en && (value != '0) && (value != `MB_UNLIMITED))
			return value - 1'b1;
		return value;
	endfunction

	assign in_run      = (state == st_run);
	assign flush       = (state == st_flush);
	assign owner       = cur.owner;
	assign owner_state = cur;
	assign read_enable = in_run && (cur.limit != '0);

	// Only the owner may delegate or yield
	always_comb
	begin
		req_ready = '0;
		req_sel   = '0;
		for (int i = 0; i < `MB_NUM_READERS; i++)
		begin
			if (cur.owner == owner_id_t'(i))
			begin
				req_ready[i] = in_run && !stack_full;
				req_sel      = req_state[i];
			end
		end
	end

	assign accept   = |(req_valid & req_ready);
	assign is_yield = accept && (req_sel.owner == `MB_YIELD_ID);
	// Child budget must be non-zero and strictly below ours in both fields
	assign is_valid = accept && !is_yield
		&& (req_sel.limit != '0) && (req_sel.limit < cur.limit)
		&& (req_sel.timeout != '0) && (req_sel.timeout < cur.timeout);
	assign exhausted = (cur.limit == '0) || (cur.timeout == '0);

	// Root owner has no parent, so it just sits on a zero budget
	assign pop  = in_run && !stack_empty && (is_yield || exhausted);
	assign push = is_valid;

	// Parent keeps what it did not hand over
	always_comb
	begin
		push_state.owner = cur.owner;
		if (cur.limit == `MB_UNLIMITED)
			push_state.limit = cur.limit;
		else
			push_state.limit = cur.limit - req_sel.limit;
		if (cur.timeout == `MB_UNLIMITED)
			push_state.timeout = cur.timeout;
		else
			push_state.timeout = cur.timeout - req_sel.timeout;
	end

	// A yield hands the unused budget back to finite parent fields
	always_comb
	begin
		pop_state = top_state;
		if (is_yield)
		begin
			if (top_state.limit != `MB_UNLIMITED)
				pop_state.limit = top_state.limit + cur.limit;
			if (top_state.timeout != `MB_UNLIMITED)
				pop_state.timeout = top_state.timeout + cur.timeout;
		end
	end

	always_comb
	begin
		dec_state         = cur;
		dec_state.limit   = dec_budget(cur.limit, read_fire);   // One per accepted read
		dec_state.timeout = dec_budget(cur.timeout, tick);
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			state <= st_run;
			cur   <= '{owner: '0, limit: `MB_UNLIMITED, timeout: `MB_UNLIMITED};
		end
		else if (flush)
		begin
			state <= st_run;
		end
		else if (pop)
		begin
			cur   <= pop_state;
			state <= st_flush;
		end
		else if (push)
		begin
			cur   <= req_sel;
			state <= st_flush;
		end
		else
		begin
			cur <= dec_state;
		end
	end

	push_pop_excl: assert property (@(posedge clk) disable iff (!resetn)
		!(push && pop));

	// A yield id must never end up as an owner
	owner_not_yield: assert property (@(posedge clk) disable iff (!resetn)
		cur.owner != `MB_YIELD_ID);

endmodule

// File: logic/delegation_stack.sv
`timescale 1ns/1ns
`include "mailbox_defs.svh"

module delegation_stack (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      push,
	input  logic                      pop,
	input  mailbox_pkg::owner_state_t push_state,
	output mailbox_pkg::owner_state_t top_state,
	output logic                      empty,
	output logic                      full
);
	import mailbox_pkg::*;

	owner_state_t               entries [`MB_STACK_DEPTH];
	logic [`MB_STACK_PTR_W-1:0] ptr;       // Number of saved parents
	logic [`MB_STACK_IDX_W-1:0] top_idx;

	assign empty     = (ptr == '0);
	assign full      = (ptr == `MB_STACK_PTR_W'(`MB_STACK_DEPTH));
	assign top_idx   = `MB_STACK_IDX_W'(ptr - 1'b1);
	assign top_state = entries[top_idx];   // Don't care while empty

	always_ff @(posedge clk)
	begin
		if (push)
			entries[ptr[`MB_STACK_IDX_W-1:0]] <= push_state;
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
			ptr <= '0;
		else if (push)
			ptr <= ptr + 1'b1;
		else if (pop)
			ptr <= ptr - 1'b1;
	end

	// FSM must hold off delegation while the stack is full
	no_push_full: assert property (@(posedge clk) disable iff (!resetn)
		push |-> !full);

	no_pop_empty: assert property (@(posedge clk) disable iff (!resetn)
		pop |-> !empty);

endmodule

// File: logic/tick_timer.sv
`timescale 1ns/1ns
`include "mailbox_defs.svh"

module tick_timer (
	input  logic clk,
	input  logic resetn,
	output logic tick
);
	logic [`MB_TICK_W-1:0] count;

	// First tick lands MB_TICK_PERIOD edges after reset
	always_ff @(posedge clk)
	begin
		if (!resetn)
			count <= `MB_TICK_W'(`MB_TICK_PERIOD - 1);
		else if (count == '0)
			count <= `MB_TICK_W'(`MB_TICK_PERIOD - 1);   // Reload
		else
			count <= count - 1'b1;
	end

	assign tick = (count == '0);

endmodule

// File: logic/msg_queue.sv
`timescale 1ns/1ns
`include "mailbox_defs.svh"

module msg_queue (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      flush,
	input  logic                      read_enable,
	input  mailbox_pkg::owner_id_t    owner,
	input  logic                      wr_valid,
	output logic                      wr_ready,
	input  mailbox_pkg::msg_word_t    wr_data,
	output mailbox_pkg::reader_mask_t rd_valid,
	input  mailbox_pkg::reader_mask_t rd_ready,
	output mailbox_pkg::msg_word_t    rd_data,
	output logic                      read_fire
);
	import mailbox_pkg::*;

	msg_word_t                  mem [`MB_QUEUE_DEPTH];
	logic [`MB_QUEUE_PTR_W-1:0] wr_ptr;
	logic [`MB_QUEUE_PTR_W-1:0] rd_ptr;
	logic [`MB_QUEUE_CNT_W-1:0] count;
	logic                       head_valid;
	logic                       owner_ready;
	logic                       wr_fire;

	assign wr_ready   = (count != `MB_QUEUE_CNT_W'(`MB_QUEUE_DEPTH)) && !flush;
	assign wr_fire    = wr_valid && wr_ready;
	assign head_valid = (count != '0) && read_enable && !flush;
	assign rd_data    = mem[rd_ptr];

	// Steer valid to the owner, listen to its ready only
	always_comb
	begin
		rd_valid    = '0;
		owner_ready = 1'b0;
		for (int i = 0; i < `MB_NUM_READERS; i++)
		begin
			if (owner == owner_id_t'(i))
			begin
				rd_valid[i] = head_valid;
				owner_ready = rd_ready[i];
			end
		end
	end

	assign read_fire = head_valid && owner_ready;

	always_ff @(posedge clk)
	begin
		if (wr_fire)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk)
	begin
		if (!resetn || flush)   // New owner starts with an empty queue
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_fire)
				wr_ptr <= wr_ptr + 1'b1;
			if (read_fire)
				rd_ptr <= rd_ptr + 1'b1;
			if (wr_fire && !read_fire)
				count <= count + 1'b1;
			else if (read_fire && !wr_fire)
				count <= count - 1'b1;
		end
	end

	count_in_range: assert property (@(posedge clk) disable iff (!resetn)
		count <= `MB_QUEUE_CNT_W'(`MB_QUEUE_DEPTH));

endmodule

// File: logic/mailbox_arb.sv
`timescale 1ns/1ns
`include "mailbox_defs.svh"

module mailbox_arb (
	input  logic                                           clk,
	input  logic                                           resetn,
	input  logic                                           wr_valid,
	output logic                                           wr_ready,
	input  mailbox_pkg::msg_word_t                         wr_data,
	output mailbox_pkg::reader_mask_t                      rd_valid,
	input  mailbox_pkg::reader_mask_t                      rd_ready,
	output mailbox_pkg::msg_word_t                         rd_data,
	input  mailbox_pkg::reader_mask_t                      req_valid,
	output mailbox_pkg::reader_mask_t                      req_ready,
	input  mailbox_pkg::owner_state_t [`MB_NUM_READERS-1:0] req_state,
	output mailbox_pkg::owner_state_t                      owner_state
);
	import mailbox_pkg::*;

	owner_state_t push_state;
	owner_state_t top_state;
	owner_id_t    owner;
	logic         push;
	logic         pop;
	logic         stack_empty;
	logic         stack_full;
	logic         tick;
	logic         read_fire;
	logic         flush;
	logic         read_enable;

	owner_fsm i_owner_fsm (
		.clk         (clk),
		.resetn      (resetn),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.req_state   (req_state),
		.tick        (tick),
		.read_fire   (read_fire),
		.top_state   (top_state),
		.stack_empty (stack_empty),
		.stack_full  (stack_full),
		.push        (push),
		.pop         (pop),
		.push_state  (push_state),
		.flush       (flush),
		.read_enable (read_enable),
		.owner       (owner),
		.owner_state (owner_state)
	);

	delegation_stack i_delegation_stack (
		.clk        (clk),
		.resetn     (resetn),
		.push       (push),
		.pop        (pop),
		.push_state (push_state),
		.top_state  (top_state),
		.empty      (stack_empty),
		.full       (stack_full)
	);

	tick_timer i_tick_timer (
		.clk    (clk),
		.resetn (resetn),
		.tick   (tick)
	);

	// Single writer, data goes to whoever owns the read side
	msg_queue i_msg_queue (
		.clk         (clk),
		.resetn      (resetn),
		.flush       (flush),
		.read_enable (read_enable),
		.owner       (owner),
		.wr_valid    (wr_valid),
		.wr_ready    (wr_ready),
		.wr_data     (wr_data),
		.rd_valid    (rd_valid),
		.rd_ready    (rd_ready),
		.rd_data     (rd_data),
		.read_fire   (read_fire)
	);

endmodule

// File: testbench/tb_mailbox_arb.sv
`timescale 1ns/1ns
`include "mailbox_defs.svh"

module tb_mailbox_arb;
	import mailbox_pkg::*;

	localparam int CLK_PERIOD     = 20;
	localparam int RESET_CYCLES   = 8;
	localparam int TRAFFIC_CYCLES = 200;
	localparam int FULL_HOLD      = 20;
	localparam int WAIT_LIMIT     = 400;   // Cycles allowed for one handshake or owner change
	localparam int MAX_WAITS      = 15;
	localparam int WATCHDOG_NS    = (RESET_CYCLES + TRAFFIC_CYCLES + FULL_HOLD
		+ MAX_WAITS * WAIT_LIMIT + 100) * CLK_PERIOD;
	localparam logic [31:0]  LFSR_SEED  = 32'h0cb0ee13;
	localparam owner_state_t ROOT_STATE =
		'{owner: 8'd0, limit: `MB_UNLIMITED, timeout: `MB_UNLIMITED};

	logic                                clk;
	logic                                resetn;
	logic                                wr_valid;
	logic                                wr_ready;
	msg_word_t                           wr_data;
	reader_mask_t                        rd_valid;
	reader_mask_t                        rd_ready;
	msg_word_t                           rd_data;
	reader_mask_t                        req_valid;
	reader_mask_t                        req_ready;
	owner_state_t [`MB_NUM_READERS-1:0]  req_state;
	owner_state_t                        owner_state;

	logic [31:0] lfsr;
	string       test_name;
	int          errors;

	// Reference model
	owner_state_t m_cur;
	owner_state_t m_stack [`MB_STACK_DEPTH];
	msg_word_t    m_mem [`MB_QUEUE_DEPTH];
	int           m_sp;
	int           m_head;
	int           m_cnt;
	int           m_tick_cnt;
	logic         m_flush;
	int           words_read;
	int           delegations;
	reader_mask_t own_mask;
	reader_mask_t exp_rd_valid;
	reader_mask_t exp_req_ready;
	logic         exp_wr_ready;
	msg_word_t    exp_head;

	mailbox_arb i_dut (
		.clk         (clk),
		.resetn      (resetn),
		.wr_valid    (wr_valid),
		.wr_ready    (wr_ready),
		.wr_data     (wr_data),
		.rd_valid    (rd_valid),
		.rd_ready    (rd_ready),
		.rd_data     (rd_data),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.req_state   (req_state),
		.owner_state (owner_state)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic owner_state_t make_state(input owner_id_t o, input budget_t l,
		input budget_t t);
		return '{owner: o, limit: l, timeout: t};
	endfunction

	function automatic budget_t spend(input budget_t left, input logic used);
		return (used && left != '0 && left != `MB_UNLIMITED) ? budget_t'(left - 12'd1) : left;
	endfunction

	function automatic budget_t keep_rest(input budget_t parent, input budget_t child);
		return (parent == `MB_UNLIMITED) ? parent : budget_t'(parent - child);
	endfunction

	function automatic budget_t give_back(input budget_t parent, input budget_t unused);
		return (parent == `MB_UNLIMITED) ? parent : budget_t'(parent + unused);
	endfunction

	assign own_mask      = reader_mask_t'(1 << m_cur.owner);
	assign exp_wr_ready  = !m_flush && (m_cnt < `MB_QUEUE_DEPTH);
	assign exp_rd_valid  = (!m_flush && m_cnt != 0 && m_cur.limit != '0) ? own_mask : '0;
	assign exp_req_ready = (!m_flush && m_sp < `MB_STACK_DEPTH) ? own_mask : '0;
	assign exp_head      = m_mem[m_head];

	always @(posedge clk)
	begin : ref_model
		owner_state_t sel;
		owner_state_t nxt;
		owner_state_t saved;
		logic         wr_fire;
		logic         rd_fire;
		logic         accept;
		logic         is_yield;
		logic         is_valid;
		int           cnt;
		int           head;

		if (!resetn)
		begin
			m_cur       <= ROOT_STATE;
			m_sp        <= 0;
			m_head      <= 0;
			m_cnt       <= 0;
			m_flush     <= 1'b0;
			m_tick_cnt  <= `MB_TICK_PERIOD - 1;
			words_read  <= 0;
			delegations <= 0;
		end
		else
		begin
			wr_fire  = wr_valid && exp_wr_ready;
			rd_fire  = (rd_ready & exp_rd_valid) != '0;
			sel      = req_state[int'(m_cur.owner)];
			accept   = (req_valid & exp_req_ready) != '0;
			is_yield = accept && (sel.owner == `MB_YIELD_ID);
			is_valid = accept && !is_yield
				&& sel.limit != '0 && sel.limit < m_cur.limit
				&& sel.timeout != '0 && sel.timeout < m_cur.timeout;
			nxt  = m_cur;
			cnt  = m_cnt + int'(wr_fire) - int'(rd_fire);
			head = rd_fire ? (m_head + 1) % `MB_QUEUE_DEPTH : m_head;
			if (wr_fire)
				m_mem[(m_head + m_cnt) % `MB_QUEUE_DEPTH] <= wr_data;
			if (rd_fire)
				words_read <= words_read + 1;
			m_tick_cnt <= (m_tick_cnt == 0) ? `MB_TICK_PERIOD - 1 : m_tick_cnt - 1;
			if (m_flush)
			begin
				m_flush <= 1'b0;   // Queue empties on the way out of flush
				cnt     = 0;
				head    = 0;
			end
			else if (m_sp != 0 && (is_yield || m_cur.limit == '0 || m_cur.timeout == '0))
			begin
				nxt = m_stack[m_sp - 1];
				if (is_yield)
				begin
					nxt.limit   = give_back(nxt.limit, m_cur.limit);
					nxt.timeout = give_back(nxt.timeout, m_cur.timeout);
				end
				m_sp    <= m_sp - 1;
				m_flush <= 1'b1;
			end
			else if (is_valid)
			begin
				saved         = m_cur;
				saved.limit   = keep_rest(m_cur.limit, sel.limit);
				saved.timeout = keep_rest(m_cur.timeout, sel.timeout);
				m_stack[m_sp] <= saved;
				m_sp          <= m_sp + 1;
				m_flush       <= 1'b1;
				delegations   <= delegations + 1;
				nxt           = sel;
			end
			else
			begin
				nxt.limit   = spend(m_cur.limit, rd_fire);
				nxt.timeout = spend(m_cur.timeout, m_tick_cnt == 0);   // Tick edge
			end
			m_cur  <= nxt;
			m_cnt  <= cnt;
			m_head <= head;
		end
	end

	task automatic wrong_value(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		errors++;
		$display("** Error [%s] %s expected %0h actual %0h", test_name, what, exp, act);
	endtask

	reset_state: assert property (@(posedge clk) $rose(resetn) |->
		(owner_state == ROOT_STATE) && (rd_valid == '0) && (req_ready == 3'b001))
		else wrong_value("state after reset", {26'd0, ROOT_STATE, 3'b000, 3'b001},
			{26'd0, $sampled(owner_state), $sampled(rd_valid), $sampled(req_ready)});

	owner_match: assert property (@(posedge clk) disable iff (!resetn)
		owner_state == m_cur)
		else wrong_value("owner_state", 64'($sampled(m_cur)), 64'($sampled(owner_state)));

	rd_valid_match: assert property (@(posedge clk) disable iff (!resetn)
		rd_valid == exp_rd_valid)
		else wrong_value("rd_valid", 64'($sampled(exp_rd_valid)), 64'($sampled(rd_valid)));

	req_ready_match: assert property (@(posedge clk) disable iff (!resetn)
		req_ready == exp_req_ready)
		else wrong_value("req_ready", 64'($sampled(exp_req_ready)), 64'($sampled(req_ready)));

	wr_ready_match: assert property (@(posedge clk) disable iff (!resetn)
		wr_ready == exp_wr_ready)
		else wrong_value("wr_ready", 64'($sampled(exp_wr_ready)), 64'($sampled(wr_ready)));

	// Words must come out in write order
	rd_data_match: assert property (@(posedge clk) disable iff (!resetn)
		(rd_valid != '0) |-> (rd_data == exp_head))
		else wrong_value("rd_data", 64'($sampled(exp_head)), 64'($sampled(rd_data)));

	task automatic drive_traffic();
		wr_valid <= (rand_bits(2) != 32'd0);   // Three writes in four
		wr_data  <= rand_bits(32);
		rd_ready <= reader_mask_t'(rand_bits(3));
	endtask

	task automatic run_traffic(input int cycles);
		repeat (cycles)
		begin
			@(posedge clk);
			drive_traffic();
		end
	endtask

	task automatic send_request(input int rdr, input owner_state_t st);
		int   waited;
		logic done;
		waited = 0;
		done   = 1'b0;
		req_valid[rdr] <= 1'b1;
		req_state[rdr] <= st;
		while (!done && waited < WAIT_LIMIT)
		begin
			@(posedge clk);
			drive_traffic();
			waited++;
			done = req_ready[rdr];   // Valid was high at this edge
		end
		req_valid[rdr] <= 1'b0;
		if (!done)
		begin
			errors++;
			$display("Request from reader %0d was never accepted in test %s", rdr, test_name);
		end
	endtask

	task automatic wait_owner(input owner_id_t who);
		int waited;
		waited = 0;
		// Owner change from the last edge shows up one edge later
		do
		begin
			@(posedge clk);
			drive_traffic();
			waited++;
		end
		while (owner_state.owner != who && waited < WAIT_LIMIT);
		if (owner_state.owner != who)
		begin
			errors++;
			$display("Ownership never returned to reader %0d in test %s", who, test_name);
		end
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("TB FAILED");
		$finish;
	end

	initial
	begin : stimulus
		owner_state_t child;
		owner_state_t yield_req;
		lfsr      = LFSR_SEED;
		errors    = 0;
		yield_req = make_state(`MB_YIELD_ID, 12'd0, 12'd0);
		test_name = "reset";
		resetn    <= 1'b0;
		wr_valid  <= 1'b0;
		wr_data   <= '0;
		rd_ready  <= '0;
		req_valid <= '0;
		req_state <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		resetn <= 1'b1;
		repeat (2) @(posedge clk);

		test_name = "delivery";
		run_traffic(TRAFFIC_CYCLES);

		test_name = "delegation";
		send_request(0, make_state(8'd1, 12'd0, 12'h100));           // Zero limit
		send_request(0, make_state(8'd2, `MB_UNLIMITED, 12'h100));   // Not below parent
		child = make_state(8'd1, budget_t'(16 + rand_bits(5)), 12'hffe);
		send_request(0, child);
		test_name = "limit";
		wait_owner(8'd0);

		test_name = "timeout";
		child = make_state(8'd2, 12'hffe, budget_t'(3 + rand_bits(3)));
		send_request(0, child);
		wait_owner(8'd0);

		// Four nested delegations fill the stack
		test_name = "yield";
		send_request(0, make_state(8'd1, budget_t'(12'h600 + rand_bits(4)),
			budget_t'(12'h600 + rand_bits(4))));
		send_request(1, make_state(8'd2, budget_t'(12'h300 + rand_bits(4)),
			budget_t'(12'h300 + rand_bits(4))));
		send_request(2, make_state(8'd0, budget_t'(12'h180 + rand_bits(4)),
			budget_t'(12'h180 + rand_bits(4))));
		send_request(0, make_state(8'd1, budget_t'(12'h020 + rand_bits(4)),
			budget_t'(12'h0c0 + rand_bits(4))));
		req_valid[1] <= 1'b1;   // Refused while full
		req_state[1] <= make_state(8'd2, 12'h008, 12'h010);
		run_traffic(FULL_HOLD);
		req_valid[1] <= 1'b0;
		wait_owner(8'd0);   // Top child runs out of reads
		send_request(0, yield_req);
		send_request(2, yield_req);
		send_request(1, yield_req);
		send_request(0, yield_req);   // Root has no parent, dropped
		run_traffic(4);

		$display("Summary: %0d errors, %0d words read, %0d delegations",
			errors, words_read, delegations);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: mailbox_arb.f
+incdir+logic
logic/mailbox_pkg.sv
logic/owner_fsm.sv
logic/delegation_stack.sv
logic/tick_timer.sv
logic/msg_queue.sv
logic/mailbox_arb.sv
testbench/tb_mailbox_arb.sv

// File: Makefile
TOP := tb_mailbox_arb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f mailbox_arb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f mailbox_arb.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf obj_dir
